// File: Bender.yml
package:
  name: core_loopback

sources:
  - include_dirs:
      - .
    files:
      - eth_pkg.sv
      - mgmt_pkg.sv
      - fifo_sync.sv
      - uart_port.sv
      - stat_counters.sv
      - frame_loopback.sv
      - mgmt_cmd.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_props.sv
      - core_tb.sv

// File: all.f
+incdir+.
eth_pkg.sv
mgmt_pkg.sv
fifo_sync.sv
uart_port.sv
stat_counters.sv
frame_loopback.sv
mgmt_cmd.sv
core_top.sv
core_props.sv
core_tb.sv

// File: core_consts.svh
// core constants for counter widths, FIFO depths, UART bit timing and management command codes
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// statistics counter bank
`define STAT_COUNT_W 32
`define STAT_NUM 5

// loopback buffer depth in beats, a power of two
`define ETH_FIFO_DEPTH 32
`define FRAME_LEN_W 16

// UART reply buffer depth and core clock cycles per bit
`define UART_TX_FIFO_DEPTH 8
`define UART_CLK_DIV 8

// management command and response bytes
`define CMD_READ_BASE 8'h10
`define CMD_CLEAR 8'h20
`define RSP_CLEAR_ACK 8'h20
`define RSP_BAD_CMD 8'hEE

`endif

// File: core_props.sv
// concurrent checks on the loopback transmit handshake and the idle UART transmit line
`default_nettype none
`timescale 1ns/1ps

module core_props (
    input  wire logic               clk,
    input  wire logic               arst_n,
    input  wire logic               tx_valid,
    input  wire eth_pkg::eth_beat_t tx_beat,
    input  wire logic               tx_ready,
    input  wire logic               uart_txd,
    input  wire logic               tx_idle
);

    // number of property failures seen so far
    int fail_cnt = 0;

    // a stalled beat stays on the bus until the sink takes it
    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
        else begin
            fail_cnt++;
            $error("transmit beat changed while the sink was stalled");
        end

    valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(tx_valid))
        else begin
            fail_cnt++;
            $error("transmit valid is unknown");
        end

    // the line rests at the stop level whenever nothing is queued or shifting
    txd_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
        tx_idle |-> uart_txd)
        else begin
            fail_cnt++;
            $error("UART line low while the transmitter is idle");
        end

endmodule

// each instance watches one block and ties the inputs it does not see to their idle level
bind frame_loopback core_props stream_props_inst (
    .clk(clk),
    .arst_n(arst_n),
    .tx_valid(tx_valid),
    .tx_beat(tx_beat),
    .tx_ready(tx_ready),
    .uart_txd(1'b1),
    .tx_idle(1'b0)
);

bind uart_port core_props uart_props_inst (
    .clk(clk),
    .arst_n(arst_n),
    .tx_valid(1'b0),
    .tx_beat('0),
    .tx_ready(1'b0),
    .uart_txd(uart_txd),
    .tx_idle(tx_idle)
);

`default_nettype wire

// File: core_tb.sv
// testbench for the core top level covering the stream loopback, UART statistics and GPIO
`default_nettype none
`timescale 1ns/1ps

`include "core_consts.svh"

module core_tb;

    // one row of the frame table where hold_low keeps the sink stalled while the frame arrives
    typedef struct packed {
        logic [7:0] len;
        logic       err;
        logic       hold_low;
    } frame_row_t;

    localparam int NUM_FRAMES = 8;
    localparam int BIT_CYCLES = `UART_CLK_DIV;

    logic               clk;
    logic               arst_n;
    logic [7:0]         sw;
    logic [7:0]         led;
    logic               uart_rxd;
    logic               uart_txd;
    logic               rx_valid;
    eth_pkg::eth_beat_t rx_beat;
    logic               tx_valid;
    eth_pkg::eth_beat_t tx_beat;
    logic               tx_ready;

    eth_pkg::eth_beat_t exp_q [$];
    logic [31:0]        model_cnt [`STAT_NUM];
    logic [7:0]         lfsr_state;
    logic               ready_random;

    frame_row_t frame_table [NUM_FRAMES] = '{
        '{len: 8'd5,  err: 1'b0, hold_low: 1'b0},
        '{len: 8'd12, err: 1'b1, hold_low: 1'b0},
        '{len: 8'd1,  err: 1'b0, hold_low: 1'b0},
        '{len: 8'd20, err: 1'b0, hold_low: 1'b0},
        '{len: 8'd40, err: 1'b0, hold_low: 1'b1},
        '{len: 8'd7,  err: 1'b1, hold_low: 1'b0},
        '{len: 8'd31, err: 1'b0, hold_low: 1'b0},
        '{len: 8'd10, err: 1'b1, hold_low: 1'b1}
    };

    logic [7:0] sw_table [4] = '{8'h00, 8'hFF, 8'hA5, 8'h3C};

    core_top dut (
        .clk(clk),
        .arst_n(arst_n),
        .sw(sw),
        .led(led),
        .uart_rxd(uart_rxd),
        .uart_txd(uart_txd),
        .rx_valid(rx_valid),
        .rx_beat(rx_beat),
        .tx_valid(tx_valid),
        .tx_beat(tx_beat),
        .tx_ready(tx_ready)
    );

    always #2 clk = ~clk;

    // right-shifting Galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end
        return state >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};
        end
    endtask

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // one clock of stream stimulus with tx_ready following the current ready mode
    task automatic step_cycle(input logic valid, input eth_pkg::eth_beat_t beat);
        logic [7:0] ready_bits;
        @(posedge clk);
        rx_valid <= valid;
        rx_beat <= beat;
        if (ready_random) begin
            take_bits(1, ready_bits);
            tx_ready <= ready_bits[0];
        end else begin
            tx_ready <= 1'b0;
        end
    endtask

    // every transfer on the transmit side must match the head of the expected queue
    always @(negedge clk) begin
        if (arst_n && tx_valid && tx_ready) begin
            assert (exp_q.size() != 0) else begin
                fail_run($sformatf("** Error at %0t: unexpected tx beat %h", $time, tx_beat));
            end
            assert (tx_beat == exp_q[0]) else begin
                fail_run($sformatf("** Error at %0t: tx beat %h, expected %h",
                    $time, tx_beat, exp_q[0]));
            end
            void'(exp_q.pop_front());
        end
    end

    always @(negedge clk) begin
        assert (dut.frame_loopback_inst.stream_props_inst.fail_cnt == 0 &&
                dut.uart_port_inst.uart_props_inst.fail_cnt == 0) else begin
            fail_run("a bound stream or UART property failed");
        end
    end

    task automatic send_frame(input frame_row_t row);
        eth_pkg::eth_beat_t beat;
        logic [7:0]         data;
        int                 stored;
        stored = 0;
        ready_random = !row.hold_low;
        for (int i = 0; i < row.len; i++) begin
            take_bits(8, data);
            beat.data = data;
            beat.last = (i == row.len - 1);
            beat.err = beat.last && row.err;
            // a stalled sink leaves room for one buffer depth because the buffer starts empty
            if (!row.hold_low || stored < `ETH_FIFO_DEPTH) begin
                exp_q.push_back(beat);
                stored++;
            end
            step_cycle(1'b1, beat);
        end
        repeat (4) step_cycle(1'b0, '0);
        if (row.err) begin
            model_cnt[mgmt_pkg::STAT_RX_BAD]++;
        end else begin
            model_cnt[mgmt_pkg::STAT_RX_GOOD]++;
            model_cnt[mgmt_pkg::STAT_RX_BYTES] += stored;
        end
        if (stored == row.len) begin
            model_cnt[mgmt_pkg::STAT_TX_FRAMES]++;
        end
        model_cnt[mgmt_pkg::STAT_RX_DROP] += row.len - stored;
    endtask

    task automatic drain_stream();
        int waited;
        waited = 0;
        ready_random = 1'b1;
        while (exp_q.size() != 0) begin
            if (waited == 1000) begin
                fail_run("timeout while waiting for the loopback to drain");
            end
            step_cycle(1'b0, '0);
            waited++;
        end
        @(negedge clk);
        assert (!tx_valid) else begin
            fail_run($sformatf("** Error at %0t: extra beat left after the frame", $time));
        end
    endtask

    task automatic uart_send(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge clk);
            uart_rxd <= frame[b];
            repeat (BIT_CYCLES - 1) @(posedge clk);
        end
    endtask

    // samples each bit near its middle as counted from the detected start edge
    task automatic uart_recv(output logic [7:0] value);
        int waited;
        waited = 0;
        value = '0;
        @(negedge clk);
        while (uart_txd) begin
            if (waited == 4000) begin
                fail_run("timeout while waiting for a UART start bit");
            end
            @(negedge clk);
            waited++;
        end
        repeat (BIT_CYCLES / 2) @(negedge clk);
        assert (!uart_txd) else begin
            fail_run("UART start bit ended before its middle");
        end
        for (int b = 0; b < 8; b++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            value[b] = uart_txd;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        assert (uart_txd) else begin
            fail_run("UART stop bit missing in a reply byte");
        end
    endtask

    task automatic mgmt_transaction(input logic [7:0] cmd, input int n,
                                    output logic [31:0] reply);
        logic [7:0] rsp_byte;
        reply = '0;
        fork
            uart_send(cmd);
            begin
                for (int i = 0; i < n; i++) begin
                    uart_recv(rsp_byte);
                    reply = {reply[23:0], rsp_byte};
                end
            end
        join
        repeat (BIT_CYCLES) @(posedge clk);
    endtask

    task automatic check_counter(input int idx, input logic [31:0] expected);
        logic [31:0] got;
        mgmt_transaction(`CMD_READ_BASE + 8'(idx), 4, got);
        assert (got == expected) else begin
            fail_run($sformatf("** Error at %0t: counter %0d read %h, expected %h",
                $time, idx, got, expected));
        end
    endtask

    task automatic check_short_reply(input logic [7:0] cmd, input logic [7:0] expected);
        logic [31:0] got;
        mgmt_transaction(cmd, 1, got);
        assert (got[7:0] == expected) else begin
            fail_run($sformatf("** Error at %0t: command %h answered %h, expected %h",
                $time, cmd, got[7:0], expected));
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        sw = '0;
        uart_rxd = 1'b1;
        rx_valid = 1'b0;
        rx_beat = '0;
        tx_ready = 1'b0;
        lfsr_state = 8'd47;
        ready_random = 1'b0;
        for (int i = 0; i < `STAT_NUM; i++) begin
            model_cnt[i] = '0;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!tx_valid && uart_txd) else begin
            fail_run($sformatf("** Error at %0t: outputs not idle after reset", $time));
        end

        foreach (frame_table[i]) begin
            send_frame(frame_table[i]);
            drain_stream();
        end

        for (int i = 0; i < `STAT_NUM; i++) begin
            check_counter(i, model_cnt[i]);
        end

        check_short_reply(`CMD_CLEAR, `RSP_CLEAR_ACK);
        for (int i = 0; i < `STAT_NUM; i++) begin
            check_counter(i, 32'd0);
        end
        check_short_reply(8'h15, `RSP_BAD_CMD);
        check_short_reply(8'h33, `RSP_BAD_CMD);

        foreach (sw_table[i]) begin
            @(posedge clk);
            sw <= sw_table[i];
            @(negedge clk);
            assert (led == sw_table[i]) else begin
                fail_run($sformatf("** Error at %0t: led %h, expected %h",
                    $time, led, sw_table[i]));
            end
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: core_top.sv
// core top level joining GPIO, the UART management port, statistics and the stream loopback
`default_nettype none
`timescale 1ns/1ps

`include "core_consts.svh"

module core_top (
    input  wire logic               clk,
    input  wire logic               arst_n,

    // GPIO
    input  wire logic [7:0]         sw,
    output logic [7:0]              led,

    // UART management, 8N1
    input  wire logic               uart_rxd,
    output logic                    uart_txd,

    // byte stream in and out
    input  wire logic               rx_valid,
    input  wire eth_pkg::eth_beat_t rx_beat,
    output logic                    tx_valid,
    output eth_pkg::eth_beat_t      tx_beat,
    input  wire logic               tx_ready
);

    logic [7:0]               mgmt_rx_byte;
    logic                     mgmt_rx_valid;
    logic [7:0]               mgmt_tx_byte;
    logic                     mgmt_tx_valid;
    logic                     mgmt_tx_idle;
    mgmt_pkg::stat_upd_t      stat_upd;
    mgmt_pkg::stat_idx_t      stat_rd_idx;
    logic [`STAT_COUNT_W-1:0] stat_rd_data;
    logic                     stat_clear;

    assign led = sw;

    uart_port uart_port_inst (
        .clk(clk),
        .arst_n(arst_n),
        .uart_rxd(uart_rxd),
        .uart_txd(uart_txd),
        .rx_byte(mgmt_rx_byte),
        .rx_byte_valid(mgmt_rx_valid),
        .tx_byte(mgmt_tx_byte),
        .tx_byte_valid(mgmt_tx_valid),
        .tx_idle(mgmt_tx_idle)
    );

    mgmt_cmd mgmt_cmd_inst (
        .clk(clk),
        .arst_n(arst_n),
        .rx_byte(mgmt_rx_byte),
        .rx_byte_valid(mgmt_rx_valid),
        .tx_idle(mgmt_tx_idle),
        .tx_byte(mgmt_tx_byte),
        .tx_byte_valid(mgmt_tx_valid),
        .rd_idx(stat_rd_idx),
        .rd_data(stat_rd_data),
        .clear(stat_clear)
    );

    stat_counters stat_counters_inst (
        .clk(clk),
        .arst_n(arst_n),
        .stat_upd(stat_upd),
        .clear(stat_clear),
        .rd_idx(stat_rd_idx),
        .rd_data(stat_rd_data)
    );

    frame_loopback frame_loopback_inst (
        .clk(clk),
        .arst_n(arst_n),
        .rx_valid(rx_valid),
        .rx_beat(rx_beat),
        .tx_valid(tx_valid),
        .tx_beat(tx_beat),
        .tx_ready(tx_ready),
        .stat_upd(stat_upd)
    );

endmodule

`default_nettype wire

// File: eth_pkg.sv
// byte-stream beat type carried by the Ethernet loopback path
`default_nettype none

package eth_pkg;

    // one byte of a frame with its end and error markers
    typedef struct packed {
        logic [7:0] data;
        // set on the final byte of a frame
        logic       last;
        // only meaningful together with last
        logic       err;
    } eth_beat_t;

endpackage

`default_nettype wire

// File: fifo_sync.sv
// single-clock first-word-fall-through FIFO with a generic payload type
`default_nettype none
`timescale 1ns/1ps

module fifo_sync #(
    parameter type T     = logic [7:0],
    // must be a power of two
    parameter int  DEPTH = 8
) (
    input  wire logic clk,
    input  wire logic arst_n,

    input  wire logic wr_en,
    input  wire T     wr_data,
    output logic      full,

    input  wire logic rd_en,
    output T          rd_data,
    output logic      empty
);

    localparam int PTR_W = $clog2(DEPTH);

    T mem [DEPTH];

    // the extra top bit tells a full buffer from an empty one
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                  (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // head entry is visible without a read request
    assign rd_data = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en && !full) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: frame_loopback.sv
// buffers received stream beats into the transmit stream and reports per-frame statistics
`default_nettype none
`timescale 1ns/1ps

`include "core_consts.svh"

module frame_loopback (
    input  wire logic                clk,
    input  wire logic                arst_n,

    input  wire logic                rx_valid,
    input  wire eth_pkg::eth_beat_t  rx_beat,

    output logic                     tx_valid,
    output eth_pkg::eth_beat_t       tx_beat,
    input  wire logic                tx_ready,

    output mgmt_pkg::stat_upd_t      stat_upd
);

    logic                    fifo_full;
    logic                    fifo_empty;
    logic                    rx_accept;
    logic                    rx_end;
    logic [`FRAME_LEN_W-1:0] len_cnt;

    assign rx_accept = rx_valid && !fifo_full;
    assign rx_end = rx_valid && rx_beat.last;

    // the receive side cannot stall, so a beat meeting a full buffer is lost
    fifo_sync #(
        .T(eth_pkg::eth_beat_t),
        .DEPTH(`ETH_FIFO_DEPTH)
    ) beat_fifo_inst (
        .clk(clk),
        .arst_n(arst_n),
        .wr_en(rx_valid),
        .wr_data(rx_beat),
        .full(fifo_full),
        .rd_en(tx_ready),
        .rd_data(tx_beat),
        .empty(fifo_empty)
    );

    // head of the buffer stays put until the sink takes it
    assign tx_valid = !fifo_empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            len_cnt <= '0;
        end else if (rx_end) begin
            len_cnt <= '0;
        end else if (rx_accept) begin
            len_cnt <= len_cnt + 1'b1;
        end
    end

    // a dropped last beat still closes the frame, but only stored beats count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stat_upd <= '0;
        end else begin
            stat_upd.frame_end <= rx_end;
            stat_upd.drop <= rx_valid && fifo_full;
            stat_upd.tx_frame <= tx_valid && tx_ready && tx_beat.last;
            if (rx_end) begin
                stat_upd.frame_bad <= rx_beat.err;
                stat_upd.frame_len <= len_cnt + `FRAME_LEN_W'(rx_accept);
            end
        end
    end

endmodule

`default_nettype wire

// File: mgmt_cmd.sv
// management command decoder that reads or clears counters and queues UART reply bytes
`default_nettype none
`timescale 1ns/1ps

`include "core_consts.svh"

module mgmt_cmd (
    input  wire logic                     clk,
    input  wire logic                     arst_n,

    input  wire logic [7:0]               rx_byte,
    input  wire logic                     rx_byte_valid,
    input  wire logic                     tx_idle,

    output logic [7:0]                    tx_byte,
    output logic                          tx_byte_valid,

    output mgmt_pkg::stat_idx_t           rd_idx,
    input  wire logic [`STAT_COUNT_W-1:0] rd_data,
    output logic                          clear
);

    localparam int RD_BYTES = `STAT_COUNT_W / 8;

    logic [7:0]               cmd_off;
    logic                     is_read;
    logic                     is_clear;
    logic                     cmd_take;
    logic [`STAT_COUNT_W-1:0] rsp_sr;
    logic [2:0]               rsp_left;

    // bytes below the read base wrap to large offsets and fall out as bad commands
    assign cmd_off = rx_byte - `CMD_READ_BASE;
    assign is_read = (cmd_off < 8'(`STAT_NUM));
    assign is_clear = (rx_byte == `CMD_CLEAR);

    // a command arriving while a reply is still in flight is ignored
    assign cmd_take = rx_byte_valid && tx_idle && (rsp_left == '0);

    assign rd_idx = cmd_off[2:0];

    // reply goes out most significant byte first
    assign tx_byte = rsp_sr[`STAT_COUNT_W-1 -: 8];
    assign tx_byte_valid = (rsp_left != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_left <= '0;
            clear <= 1'b0;
        end else begin
            clear <= cmd_take && is_clear;
            if (cmd_take) begin
                rsp_left <= is_read ? 3'(RD_BYTES) : 3'd1;
            end else if (rsp_left != '0) begin
                rsp_left <= rsp_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            if (is_read) begin
                rsp_sr <= rd_data;
            end else if (is_clear) begin
                rsp_sr <= {`RSP_CLEAR_ACK, {(`STAT_COUNT_W - 8){1'b0}}};
            end else begin
                rsp_sr <= {`RSP_BAD_CMD, {(`STAT_COUNT_W - 8){1'b0}}};
            end
        end else if (tx_byte_valid) begin
            rsp_sr <= {rsp_sr[`STAT_COUNT_W-9:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// File: mgmt_pkg.sv
// statistics update record and counter index definitions for the management side
`default_nettype none

`include "core_consts.svh"

package mgmt_pkg;

    typedef logic [2:0] stat_idx_t;

    // counter positions in the statistics bank
    localparam stat_idx_t STAT_RX_GOOD   = 3'd0;
    localparam stat_idx_t STAT_RX_BAD    = 3'd1;
    localparam stat_idx_t STAT_RX_BYTES  = 3'd2;
    localparam stat_idx_t STAT_TX_FRAMES = 3'd3;
    localparam stat_idx_t STAT_RX_DROP   = 3'd4;

    // per-cycle event record from the loopback, any mix of fields may be set at once
    typedef struct packed {
        logic                    frame_end;
        logic                    frame_bad;
        logic [`FRAME_LEN_W-1:0] frame_len;
        logic                    tx_frame;
        logic                    drop;
    } stat_upd_t;

endpackage

`default_nettype wire

// File: stat_counters.sv
// bank of wrapping statistics counters fed by loopback events, with a read port and clear
`default_nettype none
`timescale 1ns/1ps

`include "core_consts.svh"

module stat_counters (
    input  wire logic                clk,
    input  wire logic                arst_n,

    input  wire mgmt_pkg::stat_upd_t stat_upd,
    input  wire logic                clear,

    input  wire mgmt_pkg::stat_idx_t rd_idx,
    output logic [`STAT_COUNT_W-1:0] rd_data
);

    logic [`STAT_COUNT_W-1:0] stat_cnt [`STAT_NUM];

    // clear wins over any update arriving in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `STAT_NUM; i++) begin
                stat_cnt[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < `STAT_NUM; i++) begin
                stat_cnt[i] <= '0;
            end
        end else begin
            if (stat_upd.frame_end) begin
                if (stat_upd.frame_bad) begin
                    stat_cnt[mgmt_pkg::STAT_RX_BAD] <= stat_cnt[mgmt_pkg::STAT_RX_BAD] + 1'b1;
                end else begin
                    stat_cnt[mgmt_pkg::STAT_RX_GOOD] <= stat_cnt[mgmt_pkg::STAT_RX_GOOD] + 1'b1;
                    // byte total only counts frames that arrived clean
                    stat_cnt[mgmt_pkg::STAT_RX_BYTES] <= stat_cnt[mgmt_pkg::STAT_RX_BYTES] +
                        `STAT_COUNT_W'(stat_upd.frame_len);
                end
            end
            if (stat_upd.tx_frame) begin
                stat_cnt[mgmt_pkg::STAT_TX_FRAMES] <= stat_cnt[mgmt_pkg::STAT_TX_FRAMES] + 1'b1;
            end
            if (stat_upd.drop) begin
                stat_cnt[mgmt_pkg::STAT_RX_DROP] <= stat_cnt[mgmt_pkg::STAT_RX_DROP] + 1'b1;
            end
        end
    end

    assign rd_data = (rd_idx < 3'(`STAT_NUM)) ? stat_cnt[rd_idx] : '0;

endmodule

`default_nettype wire

// File: uart_port.sv
// 8N1 UART receiver and FIFO-fed transmitter running at a fixed clock divide
`default_nettype none
`timescale 1ns/1ps

`include "core_consts.svh"

module uart_port #(
    parameter int CLK_DIV = `UART_CLK_DIV
) (
    input  wire logic       clk,
    input  wire logic       arst_n,

    input  wire logic       uart_rxd,
    output logic            uart_txd,

    output logic [7:0]      rx_byte,
    output logic            rx_byte_valid,

    input  wire logic [7:0] tx_byte,
    input  wire logic       tx_byte_valid,
    output logic            tx_idle
);

    localparam int CNT_W = $clog2(CLK_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLK_DIV / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    logic [1:0]       rxd_sync;
    logic             rxd;
    rx_state_t        rx_state;
    logic [CNT_W-1:0] rx_cnt;
    logic [2:0]       rx_bit;
    logic [7:0]       rx_shift;
    logic             rx_tick;

    logic [7:0]       fifo_data;
    logic             fifo_empty;
    logic             fifo_rd;
    logic [9:0]       tx_shift;
    logic [3:0]       tx_bits;
    logic [CNT_W-1:0] tx_cnt;

    // two flops for the asynchronous line, idle level is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], uart_rxd};
        end
    end

    assign rxd = rxd_sync[1];
    assign rx_tick = (rx_cnt == CNT_LAST);

    // the start bit is checked at its middle, every later sample lands one bit period on
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_state <= RX_IDLE;
            rx_cnt <= '0;
            rx_bit <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rxd) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_cnt == CNT_HALF) begin
                        rx_cnt <= '0;
                        rx_bit <= '0;
                        // a glitch shorter than half a bit is ignored
                        rx_state <= rxd ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_tick) begin
                        rx_cnt <= '0;
                        rx_bit <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (rx_tick) begin
                        // framing errors are discarded silently
                        rx_byte_valid <= rxd;
                        rx_state <= RX_IDLE;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    rx_state <= RX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_state == RX_DATA && rx_tick) begin
            rx_shift <= {rxd, rx_shift[7:1]};
        end
        if (rx_state == RX_STOP && rx_tick) begin
            rx_byte <= rx_shift;
        end
    end

    // replies never exceed the depth, so the full flag is left open
    fifo_sync #(
        .T(logic [7:0]),
        .DEPTH(`UART_TX_FIFO_DEPTH)
    ) tx_fifo_inst (
        .clk(clk),
        .arst_n(arst_n),
        .wr_en(tx_byte_valid),
        .wr_data(tx_byte),
        .full(),
        .rd_en(fifo_rd),
        .rd_data(fifo_data),
        .empty(fifo_empty)
    );

    assign fifo_rd = (tx_bits == '0) && !fifo_empty;

    // shifter holds start, data and stop bits and refills with ones as it empties
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_shift <= '1;
            tx_bits <= '0;
            tx_cnt <= '0;
        end else if (fifo_rd) begin
            tx_shift <= {1'b1, fifo_data, 1'b0};
            tx_bits <= 4'd10;
            tx_cnt <= '0;
        end else if (tx_bits != '0) begin
            if (tx_cnt == CNT_LAST) begin
                tx_cnt <= '0;
                tx_shift <= {1'b1, tx_shift[9:1]};
                tx_bits <= tx_bits - 1'b1;
            end else begin
                tx_cnt <= tx_cnt + 1'b1;
            end
        end
    end

    assign uart_txd = tx_shift[0];
    assign tx_idle = fifo_empty && (tx_bits == '0);

endmodule

`default_nettype wire
